//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_ghrd_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/fabric_pkg.sv
`default_nettype none

// ==================================================
// fabric side: cache geometry and reset requests
// ==================================================
package fabric_pkg;

  localparam int BANK_W = 4;  // bank select, 16 banks

  // one bank is filled by a whole transfer
  localparam int BANK_WORDS = sdram_pkg::BURST_LEN * sdram_pkg::BURSTS_PER_BANK;

  // bank select on top of the word offset, 16 x 32 words
  localparam int CACHE_ADDR_W = BANK_W + $clog2(BANK_WORDS);

  // write into the instruction cache
  typedef struct packed {
    logic                               wren;
    logic [CACHE_ADDR_W-1:0]            address;  // bank, burst, beat
    logic [sdram_pkg::SDRAM_DATA_W-1:0] data;     // beat as returned
  } cache_wr_t;

  // level requests, one per reset kind
  typedef struct packed {
    logic cold;
    logic warm;
    logic debug;
  } reset_req_t;

  // pulse lengths in clk cycles
  localparam int COLD_PULSE  = 6;
  localparam int WARM_PULSE  = 2;
  localparam int DEBUG_PULSE = 32;  // long enough for the debug core

endpackage

`default_nettype wire

//--- common/sdram_pkg.sv
`default_nettype none

// ==================================================
// sdram bridge read port (f2h sdram0)
// ==================================================
package sdram_pkg;

  localparam int SDRAM_ADDR_W    = 29;  // bridge word address
  localparam int SDRAM_DATA_W    = 64;  // one read beat
  localparam int BURST_CNT_W     = 8;   // burstcount field
  localparam int BURST_LEN       = 8;   // beats per burst
  localparam int BURSTS_PER_BANK = 4;   // bursts to fill one cache bank

  // index widths inside a bank
  localparam int BEAT_IDX_W  = $clog2(BURST_LEN);        // beat within burst
  localparam int BURST_IDX_W = $clog2(BURSTS_PER_BANK);  // burst within bank

  // transfer address map
  // burst k of bank b starts at SDRAM_BASE + b*bank_words + k*BURST_LEN
  localparam logic [SDRAM_ADDR_W-1:0] SDRAM_BASE = 29'h772_0000;  // bank 0 start

  typedef logic [BURST_CNT_W-1:0] burst_cnt_t;  // burstcount value
  typedef logic [BEAT_IDX_W-1:0]  beat_idx_t;   // beat counter
  typedef logic [BURST_IDX_W-1:0] burst_idx_t;  // burst counter

  // master -> bridge
  typedef struct packed {
    logic                    read;        // held until waitrequest low
    logic [SDRAM_ADDR_W-1:0] address;     // first word of the burst
    burst_cnt_t              burstcount;  // beats requested
  } sdram_rd_req_t;

  // bridge -> master
  typedef struct packed {
    logic                    waitrequest;    // only back-pressure
    logic                    readdatavalid;  // one beat per cycle when high
    logic [SDRAM_DATA_W-1:0] readdata;
  } sdram_rd_rsp_t;

endpackage

`default_nettype wire

//--- mtu/instr_cache.sv
`timescale 1ns/1ps
`default_nettype none

// instruction cache RAM
// write port fed by the transfer unit, read port for instruction fetch
module instr_cache (
  input  wire                                 clk,
  input  wire fabric_pkg::cache_wr_t          cache_wr,    // from mtu_ctrl
  input  wire [fabric_pkg::CACHE_ADDR_W-1:0]  fetch_addr,
  output logic [sdram_pkg::SDRAM_DATA_W-1:0]  fetch_data   // one cycle after fetch_addr
);

  // 16 banks x 32 words
  logic [sdram_pkg::SDRAM_DATA_W-1:0] mem [2**fabric_pkg::CACHE_ADDR_W];

  // ==================================================
  // write port
  // ==================================================
  always_ff @(posedge clk) begin
    if (cache_wr.wren) begin
      mem[cache_wr.address] <= cache_wr.data;  // lands on this edge
    end
  end

  // ==================================================
  // fetch port
  // ==================================================
  // registered read, old data on a same-address write
  always_ff @(posedge clk) begin
    fetch_data <= mem[fetch_addr];
  end

endmodule

`default_nettype wire

//--- mtu/mtu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// memory transfer unit
// reads one bank from sdram in bursts and writes each beat into the cache
module mtu_ctrl (
  input  wire                             clk,
  input  wire                             arst_n,
  input  wire                             cold_rst,     // abort to idle
  input  wire                             enable_xfer,  // level, edge starts a transfer
  input  wire [fabric_pkg::BANK_W-1:0]    cache_bank,   // bank to fill
  output sdram_pkg::sdram_rd_req_t        sdram_req,
  input  wire sdram_pkg::sdram_rd_rsp_t   sdram_rsp,
  output fabric_pkg::cache_wr_t           cache_wr,
  output logic                            xfer_busy
);

  typedef enum logic [1:0] {
    ST_IDLE,  // waiting for enable edge
    ST_REQ,   // read held until waitrequest low
    ST_RECV   // collecting BURST_LEN beats
  } state_t;

  state_t                              state;
  logic                                en_q;        // enable seen last edge
  logic                                start;       // new transfer
  logic                                beat_ok;     // beat taken this cycle
  logic                                last_beat;
  logic                                last_burst;
  logic [fabric_pkg::BANK_W-1:0]       bank_q;      // bank latched at start
  sdram_pkg::burst_idx_t               burst_cnt;   // burst within bank
  sdram_pkg::beat_idx_t                beat_cnt;    // beat within burst
  logic [sdram_pkg::SDRAM_ADDR_W-1:0]  burst_ofs;   // word offset of current burst
  logic                                wr_en_q;
  logic [fabric_pkg::CACHE_ADDR_W-1:0] wr_addr_q;
  logic [sdram_pkg::SDRAM_DATA_W-1:0]  wr_data_q;

  assign start      = enable_xfer & ~en_q & (state == ST_IDLE);
  assign beat_ok    = (state == ST_RECV) & sdram_rsp.readdatavalid;
  assign last_beat  = (beat_cnt == sdram_pkg::beat_idx_t'(sdram_pkg::BURST_LEN - 1));
  assign last_burst = (burst_cnt == sdram_pkg::burst_idx_t'(sdram_pkg::BURSTS_PER_BANK - 1));

  // ==================================================
  // transfer FSM
  // ==================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      en_q      <= 1'b0;
      bank_q    <= '0;
      burst_cnt <= '0;
      beat_cnt  <= '0;
    end else begin
      en_q <= enable_xfer;  // edges during an abort are lost
      if (cold_rst) begin
        state <= ST_IDLE;  // cold reset wins over everything
      end else begin
        case (state)
          ST_IDLE: begin
            if (start) begin
              bank_q    <= cache_bank;
              burst_cnt <= '0;
              state     <= ST_REQ;
            end
          end
          ST_REQ: begin
            // accepted on the edge where waitrequest is low
            if (!sdram_rsp.waitrequest) begin
              beat_cnt <= '0;
              state    <= ST_RECV;
            end
          end
          ST_RECV: begin
            if (sdram_rsp.readdatavalid) begin
              beat_cnt <= beat_cnt + 1'b1;
              if (last_beat) begin
                if (last_burst) begin
                  state <= ST_IDLE;  // bank complete
                end else begin
                  burst_cnt <= burst_cnt + 1'b1;
                  state     <= ST_REQ;  // next burst right away
                end
              end
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  // ==================================================
  // beat -> cache write, one cycle later
  // ==================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_en_q <= 1'b0;
    end else begin
      wr_en_q <= beat_ok & ~cold_rst;
    end
  end

  always_ff @(posedge clk) begin
    if (beat_ok) begin
      wr_addr_q <= {bank_q, burst_cnt, beat_cnt};  // b*BANK_WORDS + k*BURST_LEN + j
      wr_data_q <= sdram_rsp.readdata;
    end
  end

  assign cache_wr = '{wren: wr_en_q, address: wr_addr_q, data: wr_data_q};

  // bank and burst offset, beat bits zero
  assign burst_ofs = {{(sdram_pkg::SDRAM_ADDR_W - fabric_pkg::CACHE_ADDR_W){1'b0}},
                      bank_q, burst_cnt, sdram_pkg::beat_idx_t'(0)};

  // request stays put while waitrequest is high
  assign sdram_req = '{
    read:       (state == ST_REQ) & ~cold_rst,
    address:    sdram_pkg::SDRAM_BASE + burst_ofs,
    burstcount: sdram_pkg::burst_cnt_t'(sdram_pkg::BURST_LEN)
  };

  assign xfer_busy = (state != ST_IDLE) & ~cold_rst;  // low for the whole abort

endmodule

`default_nettype wire

//--- source/ghrd_core.sv
`timescale 1ns/1ps
`default_nettype none

// fabric side of the board top level
// reset request pulses, sdram -> cache transfer unit, cache fetch port
module ghrd_core (
  input  wire                                 clk,
  input  wire                                 arst_n,
  input  wire fabric_pkg::reset_req_t         reset_req,    // level requests
  input  wire                                 enable_xfer,  // sw[0] on the board
  input  wire [fabric_pkg::BANK_W-1:0]        cache_bank,   // bank to fill
  input  wire sdram_pkg::sdram_rd_rsp_t       sdram_rsp,    // bridge read response
  input  wire [fabric_pkg::CACHE_ADDR_W-1:0]  fetch_addr,
  output wire sdram_pkg::sdram_rd_req_t       sdram_req,    // bridge read request
  output wire                                 cold_reset,
  output wire                                 warm_reset,
  output wire                                 debug_reset,
  output wire                                 xfer_busy,    // falls when the bank is in
  output wire [sdram_pkg::SDRAM_DATA_W-1:0]   fetch_data
);

  wire fabric_pkg::cache_wr_t cache_wr;  // mtu -> cache

  // ==================================================
  // reset request pulses
  // ==================================================
  reset_pulse #(
    .PULSE (fabric_pkg::COLD_PULSE)
  ) pulse_cold_reset (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (reset_req.cold),
    .pulse  (cold_reset)       // also aborts the transfer
  );

  reset_pulse #(
    .PULSE (fabric_pkg::WARM_PULSE)
  ) pulse_warm_reset (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (reset_req.warm),
    .pulse  (warm_reset)
  );

  reset_pulse #(
    .PULSE (fabric_pkg::DEBUG_PULSE)
  ) pulse_debug_reset (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (reset_req.debug),
    .pulse  (debug_reset)
  );

  // ==================================================
  // transfer unit and cache
  // ==================================================
  mtu_ctrl mtu_ctrl_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .cold_rst    (cold_reset),   // cold pulse forces idle
    .enable_xfer (enable_xfer),
    .cache_bank  (cache_bank),
    .sdram_req   (sdram_req),
    .sdram_rsp   (sdram_rsp),
    .cache_wr    (cache_wr),
    .xfer_busy   (xfer_busy)
  );

  instr_cache instr_cache_i (
    .clk        (clk),
    .cache_wr   (cache_wr),
    .fetch_addr (fetch_addr),  // external fetch
    .fetch_data (fetch_data)
  );

endmodule

`default_nettype wire

//--- source/reset_pulse.sv
`timescale 1ns/1ps
`default_nettype none

// rising edge of a level request -> fixed length pulse
// edges that arrive while the pulse runs are lost
module reset_pulse #(
  parameter int PULSE = fabric_pkg::COLD_PULSE  // pulse length in cycles
) (
  input  wire  clk,
  input  wire  arst_n,
  input  wire  req,    // level request
  output logic pulse   // high for PULSE cycles
);

  logic                       req_q;  // request seen on the last edge
  logic                       rise;   // low -> high of the request
  logic [$clog2(PULSE+1)-1:0] cnt;    // cycles left

  assign rise = req & ~req_q;

  // ==================================================
  // edge detect and down-counter
  // ==================================================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      req_q <= 1'b0;
      cnt   <= '0;
    end else begin
      req_q <= req;  // tracks even while busy
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;  // still running so any edge is dropped
      end else if (rise) begin
        cnt <= PULSE[$clog2(PULSE+1)-1:0];  // start a new pulse
      end
    end
  end

  // high from the cycle after the edge for exactly PULSE cycles
  assign pulse = (cnt != '0);

endmodule

`default_nettype wire

//--- testbench/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral f2h sdram bridge, read port only
// random waitrequest, queued bursts, beats with random gaps
module sdram_model (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire sdram_pkg::sdram_rd_req_t  sdram_req,
  output sdram_pkg::sdram_rd_rsp_t       sdram_rsp,
  output logic                           idle        // no beats owed
);

  typedef logic [sdram_pkg::SDRAM_ADDR_W-1:0] addr_t;

  localparam time DRIVE_DLY = 1ns;  // outputs move just after the edge

  integer      seed = 61;  // fixed seed, same run every time
  logic [31:0] rnd;
  addr_t       beat_q [$];  // addresses of beats still to return

  // upper half address, lower half inverted address
  function automatic logic [sdram_pkg::SDRAM_DATA_W-1:0] beat_data(input addr_t addr);
    logic [31:0] a32;
    a32 = 32'(addr);
    return {a32, ~a32};
  endfunction

  // ==================================================
  // request accept and beat return
  // ==================================================
  initial begin
    sdram_rsp = '0;
    idle      = 1'b1;
    forever begin
      @(posedge clk);
      if (!arst_n) begin
        beat_q.delete();  // bridge forgets everything in reset
      end else if (sdram_req.read && !sdram_rsp.waitrequest) begin
        // accepted on this edge, owe burstcount beats
        for (int j = 0; j < int'(sdram_req.burstcount); j++) begin
          beat_q.push_back(sdram_req.address + addr_t'(j));
        end
      end
      #DRIVE_DLY;
      rnd                   = $random(seed);
      sdram_rsp.waitrequest = rnd[0];  // stalls about half the cycles
      if (arst_n && beat_q.size() != 0 && rnd[2:1] != 2'b00) begin
        sdram_rsp.readdatavalid = 1'b1;
        sdram_rsp.readdata      = beat_data(beat_q.pop_front());
      end else begin
        sdram_rsp.readdatavalid = 1'b0;  // gap or nothing owed
        sdram_rsp.readdata      = '0;
      end
      idle = (beat_q.size() == 0);
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_ghrd_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ghrd_core;

  typedef logic [sdram_pkg::SDRAM_ADDR_W-1:0] sdram_addr_t;
  typedef logic [fabric_pkg::CACHE_ADDR_W-1:0] cache_addr_t;

  localparam time CLK_PERIOD   = 4ns;
  localparam time DRIVE_DLY    = 1ns;
  localparam int  N_XFERS      = 4;   // two banks, one aborted, one restart
  localparam int  WORST_FACTOR = 16;  // cycles per beat with stalls and gaps
  localparam int  WATCHDOG_CYCLES =
    N_XFERS * sdram_pkg::BURSTS_PER_BANK * sdram_pkg::BURST_LEN * WORST_FACTOR
    + 16 * fabric_pkg::DEBUG_PULSE;  // pulse tests and fetches

  logic                               clk = 1'b0;
  logic                               arst_n;
  logic [2:0]                         req_bits;  // cold, warm, debug
  fabric_pkg::reset_req_t             reset_req;
  logic                               enable_xfer;
  logic [fabric_pkg::BANK_W-1:0]      bank_sel;  // drives cache_bank
  cache_addr_t                        fetch_addr;
  logic                               fetch_en;  // fetch_addr holds a word to check
  sdram_pkg::sdram_rd_rsp_t           sdram_rsp;
  wire sdram_pkg::sdram_rd_req_t      sdram_req;
  wire                                cold_reset;
  wire                                warm_reset;
  wire                                debug_reset;
  wire                                xfer_busy;
  wire [sdram_pkg::SDRAM_DATA_W-1:0]  fetch_data;
  wire [2:0]                          pulses;  // same order as req_bits
  logic                               model_idle;
  int                                 acc_cnt;  // requests accepted this transfer
  sdram_addr_t                        last_addr;
  logic                               fetch_en_q;
  cache_addr_t                        fetch_addr_q;

  assign reset_req = fabric_pkg::reset_req_t'(req_bits);
  assign pulses    = {cold_reset, warm_reset, debug_reset};

  always #(CLK_PERIOD / 2) clk = ~clk;

  ghrd_core ghrd_core_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .reset_req   (reset_req),
    .enable_xfer (enable_xfer),
    .cache_bank  (bank_sel),
    .sdram_rsp   (sdram_rsp),
    .fetch_addr  (fetch_addr),
    .sdram_req   (sdram_req),
    .cold_reset  (cold_reset),
    .warm_reset  (warm_reset),
    .debug_reset (debug_reset),
    .xfer_busy   (xfer_busy),
    .fetch_data  (fetch_data)
  );

  sdram_model sdram_model_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .sdram_req (sdram_req),
    .sdram_rsp (sdram_rsp),
    .idle      (model_idle)
  );

  // ==================================================
  // expected values and reporting
  // ==================================================
  task automatic stop_on_failure();
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    stop_on_failure();
  endtask

  // cache offset equals the sdram offset from the base
  function automatic logic [63:0] expected_word(input cache_addr_t cache_addr);
    sdram_addr_t addr;
    logic [31:0] a32;
    addr = sdram_pkg::SDRAM_BASE + sdram_addr_t'(cache_addr);
    a32  = 32'(addr);
    return {a32, ~a32};
  endfunction

  function automatic sdram_addr_t burst_addr(input logic [fabric_pkg::BANK_W-1:0] bank,
                                             input int k);
    return sdram_pkg::SDRAM_BASE +
           sdram_addr_t'(int'(bank) * fabric_pkg::BANK_WORDS + k * sdram_pkg::BURST_LEN);
  endfunction

  function automatic int pulse_len(input int idx);
    case (idx)
      2:       return fabric_pkg::COLD_PULSE;
      1:       return fabric_pkg::WARM_PULSE;
      default: return fabric_pkg::DEBUG_PULSE;
    endcase
  endfunction

  function automatic string pulse_name(input int idx);
    case (idx)
      2:       return "cold pulse";
      1:       return "warm pulse";
      default: return "debug pulse";
    endcase
  endfunction

  // ==================================================
  // monitors and checks
  // ==================================================
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      acc_cnt      <= 0;
      last_addr    <= '0;
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      if (!xfer_busy) acc_cnt <= 0;  // fresh count for the next transfer
      else if (sdram_req.read && !sdram_rsp.waitrequest) acc_cnt <= acc_cnt + 1;
      last_addr    <= sdram_req.address;
      fetch_en_q   <= fetch_en;  // fetch_data answers one cycle later
      fetch_addr_q <= fetch_addr;
    end
  end

  // everything quiet while in reset
  assert property (@(posedge clk) !arst_n |-> ({pulses, sdram_req.read, xfer_busy} == '0))
    else report_mismatch("reset outputs", 0, $sampled({pulses, sdram_req.read, xfer_busy}));

  for (genvar i = 0; i < 3; i++) begin : g_pulse
    int unsigned high_cnt;  // edges seen with the pulse high
    always @(posedge clk or negedge arst_n) begin
      if (!arst_n) high_cnt <= 0;
      else if (pulses[i]) high_cnt <= high_cnt + 1;
      else high_cnt <= 0;
    end
    // exact length so a restart shows up as too long
    assert property (@(posedge clk) disable iff (!arst_n)
      $fell(pulses[i]) |-> high_cnt == pulse_len(i))
      else report_mismatch({pulse_name(i), " length"}, pulse_len(i), $sampled(high_cnt));
    assert property (@(posedge clk) disable iff (!arst_n)
      $rose(pulses[i]) |-> $past(req_bits[i]) && !$past(req_bits[i], 2))
      else report_mismatch({pulse_name(i), " without edge"}, 1, 0);
    assert property (@(posedge clk) disable iff (!arst_n)
      $past(req_bits[i]) && !$past(req_bits[i], 2) && !$past(pulses[i]) |-> pulses[i])
      else report_mismatch({pulse_name(i), " start"}, 1, $sampled(pulses[i]));
  end

  assert property (@(posedge clk) disable iff (!arst_n)
    $rose(xfer_busy) |-> sdram_req.read && $past(enable_xfer) && !$past(enable_xfer, 2))
    else report_mismatch("transfer start", 1, $sampled(sdram_req.read));
  assert property (@(posedge clk) disable iff (!arst_n)
    sdram_req.read |-> xfer_busy && sdram_req.burstcount == sdram_pkg::BURST_LEN)
    else report_mismatch("burstcount", sdram_pkg::BURST_LEN, $sampled(sdram_req.burstcount));
  // held under waitrequest unless cold reset pulls it
  assert property (@(posedge clk) disable iff (!arst_n)
    $past(sdram_req.read && sdram_rsp.waitrequest) && !cold_reset
    |-> sdram_req.read && sdram_req.address == last_addr)
    else report_mismatch("request hold", $sampled(last_addr), $sampled(sdram_req.address));
  assert property (@(posedge clk) disable iff (!arst_n)
    sdram_req.read && !sdram_rsp.waitrequest
    |-> sdram_req.address == burst_addr(bank_sel, acc_cnt))
    else report_mismatch("burst address", burst_addr($sampled(bank_sel), $sampled(acc_cnt)),
                         $sampled(sdram_req.address));
  assert property (@(posedge clk) disable iff (!arst_n)
    $fell(xfer_busy) && !cold_reset |-> acc_cnt == sdram_pkg::BURSTS_PER_BANK)
    else report_mismatch("bursts per bank", sdram_pkg::BURSTS_PER_BANK, $sampled(acc_cnt));
  assert property (@(posedge clk) disable iff (!arst_n)
    cold_reset |-> !xfer_busy && !sdram_req.read)
    else report_mismatch("abort", 0, $sampled({xfer_busy, sdram_req.read}));
  assert property (@(posedge clk) disable iff (!arst_n)
    fetch_en_q |-> fetch_data == expected_word(fetch_addr_q))
    else report_mismatch("fetch", expected_word($sampled(fetch_addr_q)), $sampled(fetch_data));

  // ==================================================
  // stimulus
  // ==================================================
  task automatic next_drive();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic pulse_once(input int idx);
    req_bits[idx] = 1'b1;
    wait (pulses[idx]);
    wait (!pulses[idx]);
    next_drive();
    req_bits[idx] = 1'b0;
    next_drive();
  endtask

  task automatic debug_retrigger();
    req_bits[0] = 1'b1;
    wait (pulses[0]);
    repeat (4) next_drive();
    req_bits[0] = 1'b0;
    repeat (2) next_drive();
    req_bits[0] = 1'b1;  // edge inside the running pulse
    wait (!pulses[0]);
    repeat (4) next_drive();  // a late restart would rise here
    req_bits[0] = 1'b0;
    next_drive();
  endtask

  task automatic run_transfer(input logic [fabric_pkg::BANK_W-1:0] bank);
    bank_sel    = bank;
    enable_xfer = 1'b1;
    wait (xfer_busy);
    wait (!xfer_busy);  // falling edge ends the transfer
    next_drive();
    enable_xfer = 1'b0;
    next_drive();
  endtask

  task automatic fetch_bank(input logic [fabric_pkg::BANK_W-1:0] bank);
    for (int w = 0; w < fabric_pkg::BANK_WORDS; w++) begin
      fetch_addr = cache_addr_t'(int'(bank) * fabric_pkg::BANK_WORDS + w);
      fetch_en   = 1'b1;
      next_drive();
    end
    fetch_en = 1'b0;
    repeat (2) next_drive();  // last word still in flight
  endtask

  task automatic abort_and_restart(input logic [fabric_pkg::BANK_W-1:0] bank);
    bank_sel    = bank;
    enable_xfer = 1'b1;
    wait (sdram_rsp.readdatavalid);  // first burst coming back
    repeat (3) next_drive();
    req_bits[2] = 1'b1;
    wait (cold_reset);
    wait (!cold_reset);
    next_drive();
    req_bits[2] = 1'b0;
    enable_xfer = 1'b0;
    wait (model_idle);  // stale beats of the aborted burst drained
    next_drive();
    run_transfer(bank);
  endtask

  initial begin
    arst_n      = 1'b0;
    req_bits    = '0;
    enable_xfer = 1'b0;
    bank_sel    = '0;
    fetch_addr  = '0;
    fetch_en    = 1'b0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    arst_n = 1'b1;
    next_drive();
    pulse_once(2);
    pulse_once(1);
    pulse_once(0);
    debug_retrigger();
    run_transfer(4'd3);
    fetch_bank(4'd3);
    run_transfer(4'd12);
    fetch_bank(4'd12);
    abort_and_restart(4'd7);
    fetch_bank(4'd7);
    $display("PASS: all tests");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    stop_on_failure();
  end

endmodule

`default_nettype wire

//--- vlog.f
common/sdram_pkg.sv
common/fabric_pkg.sv
source/reset_pulse.sv
mtu/mtu_ctrl.sv
mtu/instr_cache.sv
source/ghrd_core.sv
testbench/sdram_model.sv
testbench/tb_ghrd_core.sv
